// ==== cpu_bus_sys.f ====
hdl/cpu_bus_pkg.sv
hdl/dmem_ram.sv
hdl/axil_periph_regs.sv
hdl/axi_lite_master.sv
hdl/cpu_bus_master_axil.sv
hdl/cpu_bus_sys.sv
tb/cpu_bus_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the fail message
rm -rf obj_dir build.log sim.log
verilator --binary --timing -j 0 --top-module cpu_bus_sys_tb \
  -f cpu_bus_sys.f -o sim_tb --Mdir obj_dir > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || { echo "simulation run failed, see sim.log"; exit 1; }
grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "test failed" sim.log || { echo "PASS"; exit 0; }

// ==== tb/cpu_bus_sys_tb.sv ====
`timescale 1ns/1ns

module cpu_bus_sys_tb import cpu_bus_pkg::*; ();

  localparam int TB_WORDS    = 64;
  localparam int NUM_RANDOM  = 400;
  localparam int RAND_SEED   = 63880;
  // every operation gets up to 20 cycles, preload, readback and final sweep included
  localparam int CYCLE_LIMIT = (NUM_RANDOM + 3 * TB_WORDS + 8) * 20;

  logic     CLK_I;
  logic     rst_i;
  logic     mem_valid_i;
  mem_req_t mem_req_i;
  data_t    mem_rdata_o;
  logic     mem_done_o;
  logic     mem_err_o;

  data_t dmem_model [TB_WORDS];
  data_t periph_model [4];
  int    error_count;
  int    op_count;
  int    cycle_count;

  cpu_bus_sys #(
    .DMEM_WORDS (TB_WORDS)
  ) UUT (
    .CLK_I       (CLK_I),
    .rst_i       (rst_i),
    .mem_valid_i (mem_valid_i),
    .mem_req_i   (mem_req_i),
    .mem_rdata_o (mem_rdata_o),
    .mem_done_o  (mem_done_o),
    .mem_err_o   (mem_err_o)
  );

  always #5 CLK_I = ~CLK_I;

  // watchdog
  always @(posedge CLK_I) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      error_count = error_count + 1;
      $display("summary: %0d errors in %0d operations", error_count, op_count);
      $display("test failed");
      $finish;
    end
  end

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      error_count = error_count + 1;
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h got %h", name, exp, act);
      error_count = error_count + 1;
    end
  endtask

  // new bytes only where the strobe is set
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  // idle cycles, no done may show up here
  task automatic idle_gap(input int cycles);
    repeat (cycles) begin
      @(negedge CLK_I);
      if (mem_done_o) begin
        $display("error: done pulse seen while no request was pending");
        error_count = error_count + 1;
      end
    end
  endtask

  // one request, held until done, sampled on the falling edge
  task automatic bus_access(input logic wen, input addr_t addr, input data_t wdata,
                            input strb_t strb, output data_t rdata, output logic err);
    @(negedge CLK_I);
    mem_valid_i     = 1'b1;
    mem_req_i.wen   = wen;
    mem_req_i.addr  = addr;
    mem_req_i.wdata = wdata;
    mem_req_i.strb  = strb;
    @(negedge CLK_I);
    while (!mem_done_o) @(negedge CLK_I);
    rdata       = mem_rdata_o;
    err         = mem_err_o;
    mem_valid_i = 1'b0;
    mem_req_i   = '0;
  endtask

  // predict from the model, run the access, compare
  task automatic run_op(input logic wen, input addr_t addr, input data_t wdata,
                        input strb_t strb);
    data_t   exp_data;
    logic    exp_err;
    data_t   got_data;
    logic    got_err;
    region_t region;
    int      idx;
    region   = addr[31:16];
    exp_data = '0;
    exp_err  = 1'b0;
    if (region == DMEM_REGION) begin
      idx = int'(addr[31:2]) % TB_WORDS;
      if (wen) dmem_model[idx] = merge_bytes(dmem_model[idx], wdata, strb);
      else exp_data = dmem_model[idx];
    end else if (region == PERIPH_REGION && addr[15:4] == 12'h000) begin
      if (wen) periph_model[addr[3:2]] = merge_bytes(periph_model[addr[3:2]], wdata, strb);
      else exp_data = periph_model[addr[3:2]];
    end else begin
      // unmapped peripheral offset or unknown region
      exp_err = 1'b1;
    end
    bus_access(wen, addr, wdata, strb, got_data, got_err);
    op_count = op_count + 1;
    check_data("mem_rdata_o", exp_data, got_data);
    check_err("mem_err_o", exp_err, got_err);
  endtask

  task automatic random_op();
    int      kind;
    logic    wen;
    strb_t   strb;
    logic [15:0] offs;
    region_t region;
    addr_t   addr;
    kind   = $urandom_range(0, 9);
    wen    = 1'($urandom_range(0, 1));
    strb   = strb_t'($urandom_range(0, 15));
    offs   = 16'($urandom);
    offs[1:0] = 2'b00;
    if (kind <= 4) begin
      addr = {DMEM_REGION, offs};
    end else if (kind <= 7) begin
      addr = {PERIPH_REGION, 12'h000, offs[3:0]};
    end else if (kind == 8) begin
      if (offs[15:4] == 12'h000) offs[15:4] = 12'h001;
      addr = {PERIPH_REGION, offs};
    end else begin
      region = region_t'($urandom);
      while (region == DMEM_REGION || region == PERIPH_REGION) region = region_t'($urandom);
      addr = {region, offs};
    end
    run_op(wen, addr, data_t'($urandom), strb);
  endtask

  initial begin
    CLK_I       = 1'b0;
    rst_i       = 1'b1;
    mem_valid_i = 1'b0;
    mem_req_i   = '0;
    error_count = 0;
    op_count    = 0;
    cycle_count = 0;
    void'($urandom(RAND_SEED));
    for (int i = 0; i < TB_WORDS; i++) dmem_model[i] = '0;
    for (int i = 0; i < 4; i++) periph_model[i] = '0;
    repeat (2) @(negedge CLK_I);
    rst_i = 1'b0;

    // quiet bus after reset, registers start at zero
    idle_gap(16);
    for (int i = 0; i < 4; i++) run_op(1'b0, {PERIPH_REGION, 16'(i * 4)}, '0, 4'h0);

    // preload every RAM word, then read it all back
    for (int i = 0; i < TB_WORDS; i++) begin
      run_op(1'b1, {DMEM_REGION, 16'(i * 4)}, data_t'($urandom), 4'hF);
    end
    for (int i = 0; i < TB_WORDS; i++) run_op(1'b0, {DMEM_REGION, 16'(i * 4)}, '0, 4'h0);

    for (int n = 0; n < NUM_RANDOM; n++) begin
      random_op();
      idle_gap($urandom_range(0, 3));
    end

    // final sweep shows error accesses left nothing behind
    for (int i = 0; i < TB_WORDS; i++) run_op(1'b0, {DMEM_REGION, 16'(i * 4)}, '0, 4'h0);
    for (int i = 0; i < 4; i++) run_op(1'b0, {PERIPH_REGION, 16'(i * 4)}, '0, 4'h0);

    $display("summary: %0d errors in %0d operations", error_count, op_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hdl/cpu_bus_sys.sv ====
`timescale 1ns/1ns

module cpu_bus_sys import cpu_bus_pkg::*; #(
  parameter int DMEM_WORDS = 1024
) (
  input  logic     CLK_I,
  input  logic     rst_i,
  input  logic     mem_valid_i,
  input  mem_req_t mem_req_i,
  output data_t    mem_rdata_o,
  output logic     mem_done_o,
  output logic     mem_err_o
);

  logic      start_read;
  logic      start_write;
  logic      done_read;
  logic      done_write;
  data_t     axil_rdata;
  logic      axil_err;
  addr_t     req_addr;
  data_t     req_wdata;
  strb_t     req_strb;
  logic      dmem_en;
  logic      dmem_wen;
  data_t     dmem_rdata;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  cpu_bus_master_axil u_master (
    .CLK_I         (CLK_I),
    .rst_i         (rst_i),
    .mem_valid_i   (mem_valid_i),
    .mem_req_i     (mem_req_i),
    .mem_rdata_o   (mem_rdata_o),
    .mem_done_o    (mem_done_o),
    .mem_err_o     (mem_err_o),
    .start_read_o  (start_read),
    .start_write_o (start_write),
    .done_read_i   (done_read),
    .done_write_i  (done_write),
    .axil_rdata_i  (axil_rdata),
    .axil_err_i    (axil_err),
    .req_addr_o    (req_addr),
    .req_wdata_o   (req_wdata),
    .req_strb_o    (req_strb),
    .dmem_en_o     (dmem_en),
    .dmem_wen_o    (dmem_wen),
    .dmem_rdata_i  (dmem_rdata)
  );

  axi_lite_master u_axil_master (
    .CLK_I         (CLK_I),
    .rst_i         (rst_i),
    .start_read_i  (start_read),
    .start_write_i (start_write),
    .addr_i        (req_addr),
    .wdata_i       (req_wdata),
    .wstrb_i       (req_strb),
    .done_read_o   (done_read),
    .done_write_o  (done_write),
    .rdata_o       (axil_rdata),
    .err_o         (axil_err),
    .axil_req_o    (axil_req),
    .axil_rsp_i    (axil_rsp)
  );

  dmem_ram #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .CLK_I   (CLK_I),
    .en_i    (dmem_en),
    .wen_i   (dmem_wen),
    .addr_i  (req_addr),
    .wdata_i (req_wdata),
    .strb_i  (req_strb),
    .rdata_o (dmem_rdata)
  );

  axil_periph_regs u_periph (
    .CLK_I      (CLK_I),
    .rst_i      (rst_i),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

endmodule

// ==== hdl/cpu_bus_master_axil.sv ====
`timescale 1ns/1ns

module cpu_bus_master_axil import cpu_bus_pkg::*; (
  input  logic     CLK_I,
  input  logic     rst_i,

  // cpu side
  input  logic     mem_valid_i,
  input  mem_req_t mem_req_i,
  output data_t    mem_rdata_o,
  output logic     mem_done_o,
  output logic     mem_err_o,

  // axi master control
  output logic     start_read_o,
  output logic     start_write_o,
  input  logic     done_read_i,
  input  logic     done_write_i,
  input  data_t    axil_rdata_i,
  input  logic     axil_err_i,

  // shared request fields, to RAM and AXI master
  output addr_t    req_addr_o,
  output data_t    req_wdata_o,
  output strb_t    req_strb_o,

  // data RAM
  output logic     dmem_en_o,
  output logic     dmem_wen_o,
  input  data_t    dmem_rdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    AXIL_WAIT,
    DMEM_WAIT,
    ERR_DONE
  } state_t;

  state_t   state;
  mem_req_t req_q;
  region_t  region;
  logic     axil_done;

  assign region = mem_req_i.addr[31:16];

  // only the done matching the request direction ends the access
  assign axil_done = req_q.wen ? done_write_i : done_read_i;

  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      state         <= IDLE;
      req_q         <= '0;
      mem_rdata_o   <= '0;
      mem_done_o    <= 1'b0;
      mem_err_o     <= 1'b0;
      start_read_o  <= 1'b0;
      start_write_o <= 1'b0;
      dmem_en_o     <= 1'b0;
    end else begin
      // single cycle pulses
      mem_done_o    <= 1'b0;
      start_read_o  <= 1'b0;
      start_write_o <= 1'b0;
      case (state)
        IDLE: begin
          // cpu drops valid during the done cycle, so skip it there
          if (mem_valid_i && !mem_done_o) begin
            req_q <= mem_req_i;
            case (region)
              DMEM_REGION: begin
                dmem_en_o <= 1'b1;
                state     <= DMEM_WAIT;
              end
              PERIPH_REGION: begin
                start_write_o <= mem_req_i.wen;
                start_read_o  <= !mem_req_i.wen;
                state         <= AXIL_WAIT;
              end
              default: state <= ERR_DONE;
            endcase
          end
        end
        AXIL_WAIT: begin
          if (axil_done) begin
            mem_rdata_o <= req_q.wen ? '0 : axil_rdata_i;
            mem_err_o   <= axil_err_i;
            mem_done_o  <= 1'b1;
            state       <= IDLE;
          end
        end
        DMEM_WAIT: begin
          // first cycle is the RAM access, second one picks up its data
          if (dmem_en_o) begin
            dmem_en_o <= 1'b0;
          end else begin
            mem_rdata_o <= req_q.wen ? '0 : dmem_rdata_i;
            mem_err_o   <= 1'b0;
            mem_done_o  <= 1'b1;
            state       <= IDLE;
          end
        end
        ERR_DONE: begin
          // unmapped address, never forwarded
          mem_rdata_o <= '0;
          mem_err_o   <= 1'b1;
          mem_done_o  <= 1'b1;
          state       <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign req_addr_o  = req_q.addr;
  assign req_wdata_o = req_q.wdata;
  assign req_strb_o  = req_q.strb;
  assign dmem_wen_o  = req_q.wen;

endmodule

// ==== hdl/axi_lite_master.sv ====
`timescale 1ns/1ns

module axi_lite_master import cpu_bus_pkg::*; (
  input  logic      CLK_I,
  input  logic      rst_i,

  // transaction control
  input  logic      start_read_i,
  input  logic      start_write_i,
  input  addr_t     addr_i,
  input  data_t     wdata_i,
  input  strb_t     wstrb_i,
  output logic      done_read_o,
  output logic      done_write_o,
  output data_t     rdata_o,
  output logic      err_o,

  // AXI4-Lite bus
  output axil_req_t axil_req_o,
  input  axil_rsp_t axil_rsp_i
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR_DATA,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;

  logic awvalid_q;
  logic wvalid_q;
  logic bready_q;
  logic arvalid_q;
  logic rready_q;
  logic wr_err_q;
  logic rd_err_q;
  logic aw_done;
  logic w_done;

  // channel is finished once it was accepted before or is accepted now
  assign aw_done = !awvalid_q || axil_rsp_i.awready;
  assign w_done  = !wvalid_q || axil_rsp_i.wready;

  // write side
  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      wr_state     <= WR_IDLE;
      awvalid_q    <= 1'b0;
      wvalid_q     <= 1'b0;
      bready_q     <= 1'b0;
      wr_err_q     <= 1'b0;
      done_write_o <= 1'b0;
    end else begin
      done_write_o <= 1'b0;
      case (wr_state)
        WR_IDLE: begin
          if (start_write_i) begin
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
            wr_state  <= WR_ADDR_DATA;
          end
        end
        WR_ADDR_DATA: begin
          if (awvalid_q && axil_rsp_i.awready) awvalid_q <= 1'b0;
          if (wvalid_q && axil_rsp_i.wready) wvalid_q <= 1'b0;
          if (aw_done && w_done) begin
            bready_q <= 1'b1;
            wr_state <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (axil_rsp_i.bvalid) begin
            bready_q     <= 1'b0;
            wr_err_q     <= axil_rsp_i.bresp[1];
            done_write_o <= 1'b1;
            wr_state     <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  // read side
  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      rd_state    <= RD_IDLE;
      arvalid_q   <= 1'b0;
      rready_q    <= 1'b0;
      rd_err_q    <= 1'b0;
      rdata_o     <= '0;
      done_read_o <= 1'b0;
    end else begin
      done_read_o <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (start_read_i) begin
            arvalid_q <= 1'b1;
            rd_state  <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (axil_rsp_i.arready) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
            rd_state  <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (axil_rsp_i.rvalid) begin
            rready_q    <= 1'b0;
            rdata_o     <= axil_rsp_i.rdata;
            rd_err_q    <= axil_rsp_i.rresp[1];
            done_read_o <= 1'b1;
            rd_state    <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // error belongs to whichever done is pulsing
  assign err_o = done_read_o ? rd_err_q : wr_err_q;

  // addr and data stay stable from start until done
  assign axil_req_o.araddr  = addr_i;
  assign axil_req_o.arvalid = arvalid_q;
  assign axil_req_o.rready  = rready_q;
  assign axil_req_o.awaddr  = addr_i;
  assign axil_req_o.awvalid = awvalid_q;
  assign axil_req_o.wdata   = wdata_i;
  assign axil_req_o.wstrb   = wstrb_i;
  assign axil_req_o.wvalid  = wvalid_q;
  assign axil_req_o.bready  = bready_q;

endmodule

// ==== hdl/axil_periph_regs.sv ====
`timescale 1ns/1ns

module axil_periph_regs import cpu_bus_pkg::*; (
  input  logic      CLK_I,
  input  logic      rst_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ACK,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACK,
    RD_DATA
  } rd_state_t;

  wr_state_t wr_state;
  rd_state_t rd_state;

  data_t     regs [4];
  logic      awready_q;
  logic      wready_q;
  logic      bvalid_q;
  axi_resp_t bresp_q;
  logic      arready_q;
  logic      rvalid_q;
  axi_resp_t rresp_q;
  data_t     rdata_q;
  logic      wr_hit;
  logic      rd_hit;

  // only offsets 0x0..0xC are backed by registers
  assign wr_hit = axil_req_i.awaddr[15:4] == '0;
  assign rd_hit = axil_req_i.araddr[15:4] == '0;

  // address and data accepted together, then the response
  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      wr_state  <= WR_IDLE;
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      bresp_q   <= RESP_OKAY;
      for (int r = 0; r < 4; r++) regs[r] <= '0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (axil_req_i.awvalid && axil_req_i.wvalid) begin
            awready_q <= 1'b1;
            wready_q  <= 1'b1;
            wr_state  <= WR_ACK;
          end
        end
        WR_ACK: begin
          // both valids are still held here, so this is the handshake
          awready_q <= 1'b0;
          wready_q  <= 1'b0;
          if (wr_hit) begin
            for (int i = 0; i < 4; i++) begin
              if (axil_req_i.wstrb[i]) begin
                regs[axil_req_i.awaddr[3:2]][8*i +: 8] <= axil_req_i.wdata[8*i +: 8];
              end
            end
          end
          bresp_q  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
          bvalid_q <= 1'b1;
          wr_state <= WR_RESP;
        end
        WR_RESP: begin
          if (axil_req_i.bready) begin
            bvalid_q <= 1'b0;
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK_I) begin
    if (rst_i) begin
      rd_state  <= RD_IDLE;
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
      rresp_q   <= RESP_OKAY;
      rdata_q   <= '0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (axil_req_i.arvalid) begin
            arready_q <= 1'b1;
            rd_state  <= RD_ACK;
          end
        end
        RD_ACK: begin
          arready_q <= 1'b0;
          rdata_q   <= rd_hit ? regs[axil_req_i.araddr[3:2]] : '0;
          rresp_q   <= rd_hit ? RESP_OKAY : RESP_SLVERR;
          rvalid_q  <= 1'b1;
          rd_state  <= RD_DATA;
        end
        RD_DATA: begin
          if (axil_req_i.rready) begin
            rvalid_q <= 1'b0;
            rd_state <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  assign axil_rsp_o.arready = arready_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.awready = awready_q;
  assign axil_rsp_o.wready  = wready_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.bvalid  = bvalid_q;

endmodule

// ==== hdl/dmem_ram.sv ====
`timescale 1ns/1ns

module dmem_ram import cpu_bus_pkg::*; #(
  parameter int DMEM_WORDS = 1024
) (
  input  logic  CLK_I,
  input  logic  en_i,
  input  logic  wen_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t strb_i,
  output data_t rdata_o
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  data_t mem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  // word index, upper address bits just wrap
  assign idx = addr_i[IDX_W+1:2];

  always_ff @(posedge CLK_I) begin
    if (en_i) begin
      if (wen_i) begin
        for (int i = 0; i < 4; i++) begin
          if (strb_i[i]) begin
            mem[idx][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

// ==== hdl/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

  // basic bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [15:0] region_t;

  // AXI response codes, 2 and 3 count as errors
  typedef logic [1:0] axi_resp_t;
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // address map, upper 16 bits of the byte address
  localparam region_t DMEM_REGION   = 16'h0010;
  localparam region_t PERIPH_REGION = 16'h0100;

  // cpu load/store request
  typedef struct packed {
    logic  wen;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  // master to slave
  typedef struct packed {
    addr_t araddr;
    logic  arvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  bready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic      arready;
    data_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      awready;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
  } axil_rsp_t;

endpackage
